// ==== design/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] pc_t;
    typedef logic [5:0]  preg_t;
    typedef logic [5:0]  rob_t;
    typedef logic [3:0]  optype_t;
    typedef logic [7:0]  maddr_t;  // Word address, byte address bits 9:2
    typedef logic [3:0]  cidx_t;
    typedef logic [3:0]  ctag_t;

    localparam optype_t OP_LW = 4'd8;
    localparam optype_t OP_SW = 4'd10;

    localparam int SB_DEPTH      = 4;
    localparam int SB_PTR_W      = $clog2(SB_DEPTH);
    localparam int REFILL_CYCLES = 4;
    localparam int TIMER_W       = $clog2(REFILL_CYCLES + 1);
    localparam int ADDR_LSB      = 2;
    localparam int MADDR_W       = 8;
    localparam int MEM_WORDS     = 256;
    localparam int CIDX_W        = 4;
    localparam int CTAG_W        = 4;
    localparam int CACHE_LINES   = 16;

    typedef struct packed {
        logic  valid;
        pc_t   pc;
        preg_t dest;
        rob_t  rob;
        word_t result;
    } alu_issue_t;

    // result carries the address for LW and SW
    typedef struct packed {
        logic    valid;
        pc_t     pc;
        optype_t optype;
        preg_t   dest;
        rob_t    rob;
        word_t   result;
        word_t   store_data;
    } mem_issue_t;

    typedef struct packed {
        logic  valid;
        pc_t   pc;
        preg_t dest;
        rob_t  rob;
        word_t data;
    } complete_t;

    typedef struct packed {
        maddr_t addr;
        word_t  data;
    } sb_entry_t;

    typedef struct packed {
        logic  hit;
        word_t data;
    } lookup_t;

    typedef enum logic [1:0] {
        IDLE,
        REFILL,
        FILL
    } miss_state_t;

endpackage

`default_nettype wire

// ==== design/store_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

module store_buffer (
    input  logic               clk,
    input  logic               rstn,
    input  logic               push,
    input  mem_pkg::sb_entry_t push_entry,
    input  logic               pop,
    output mem_pkg::sb_entry_t head,
    output logic               empty,
    output logic               full,
    input  mem_pkg::maddr_t    load_addr,
    output mem_pkg::lookup_t   fwd
);

    mem_pkg::sb_entry_t entries [mem_pkg::SB_DEPTH];

    logic [mem_pkg::SB_PTR_W-1:0] wr_ptr;
    logic [mem_pkg::SB_PTR_W-1:0] rd_ptr;
    logic [mem_pkg::SB_PTR_W:0]   count;

    assign head  = entries[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == mem_pkg::SB_DEPTH);

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= push_entry;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Walk oldest to youngest so the last match wins
    always_comb begin
        logic [mem_pkg::SB_PTR_W-1:0] idx;
        fwd = '0;
        for (int i = 0; i < mem_pkg::SB_DEPTH; i++) begin
            idx = rd_ptr + i[mem_pkg::SB_PTR_W-1:0];
            if (i < int'(count) && entries[idx].addr == load_addr) begin
                fwd.hit  = 1'b1;
                fwd.data = entries[idx].data;
            end
        end
    end

    a_no_push_full: assert property (@(posedge clk) disable iff (!rstn)
        push |-> !full);

    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rstn)
        pop |-> !empty);

endmodule

`default_nettype wire

// ==== design/dcache.sv ====
`timescale 1ns/1ns
`default_nettype none

module dcache (
    input  logic             clk,
    input  logic             rstn,
    input  mem_pkg::maddr_t  lookup_addr,
    output mem_pkg::lookup_t lookup,
    input  logic             fill_en,
    input  mem_pkg::maddr_t  fill_addr,
    input  mem_pkg::word_t   fill_data,
    input  logic             upd_en,
    input  mem_pkg::maddr_t  upd_addr,
    input  mem_pkg::word_t   upd_data
);

    logic [mem_pkg::CACHE_LINES-1:0] line_valid;
    mem_pkg::ctag_t tags  [mem_pkg::CACHE_LINES];
    mem_pkg::word_t words [mem_pkg::CACHE_LINES];

    mem_pkg::cidx_t lk_idx;
    mem_pkg::ctag_t lk_tag;
    mem_pkg::cidx_t fill_idx;
    mem_pkg::ctag_t fill_tag;
    mem_pkg::cidx_t upd_idx;
    mem_pkg::ctag_t upd_tag;
    logic           upd_hit;

    // Index is the low part of the word address, tag the rest
    assign lk_idx   = lookup_addr[mem_pkg::CIDX_W-1:0];
    assign lk_tag   = lookup_addr[mem_pkg::CIDX_W +: mem_pkg::CTAG_W];
    assign fill_idx = fill_addr[mem_pkg::CIDX_W-1:0];
    assign fill_tag = fill_addr[mem_pkg::CIDX_W +: mem_pkg::CTAG_W];
    assign upd_idx  = upd_addr[mem_pkg::CIDX_W-1:0];
    assign upd_tag  = upd_addr[mem_pkg::CIDX_W +: mem_pkg::CTAG_W];

    assign upd_hit = line_valid[upd_idx] && (tags[upd_idx] == upd_tag);

    always_comb begin
        lookup.hit  = line_valid[lk_idx] && (tags[lk_idx] == lk_tag);
        lookup.data = words[lk_idx];
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            line_valid <= '0;
        end else if (fill_en) begin
            line_valid[fill_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tags[fill_idx]  <= fill_tag;
            words[fill_idx] <= fill_data;
        end
        // Write-through store, no allocate on miss
        if (upd_en && upd_hit) begin
            words[upd_idx] <= upd_data;
        end
    end

    a_fill_upd_apart: assert property (@(posedge clk) disable iff (!rstn)
        !(fill_en && upd_en && fill_idx == upd_idx));

endmodule

`default_nettype wire

// ==== design/data_mem.sv ====
`timescale 1ns/1ns
`default_nettype none

module data_mem (
    input  logic            clk,
    input  mem_pkg::maddr_t addr,
    input  logic            we,
    input  mem_pkg::word_t  wdata,
    output mem_pkg::word_t  rdata
);

    mem_pkg::word_t mem [mem_pkg::MEM_WORDS];

    // Single port, read returns the old word on a write cycle
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

// ==== design/refill_timer.sv ====
`timescale 1ns/1ns
`default_nettype none

module refill_timer (
    input  logic clk,
    input  logic rstn,
    input  logic start,
    output logic done
);

    logic [mem_pkg::TIMER_W-1:0] cnt;
    logic                        running;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cnt     <= '0;
            running <= 1'b0;
        end else if (start) begin
            cnt     <= mem_pkg::TIMER_W'(mem_pkg::REFILL_CYCLES);
            running <= 1'b1;
        end else if (running) begin
            if (cnt != '0) cnt <= cnt - 1'b1;
            else running <= 1'b0;  // Done cycle ends the run
        end
    end

    assign done = running && (cnt == '0);

endmodule

`default_nettype wire

// ==== design/miss_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module miss_ctrl (
    input  logic                clk,
    input  logic                rstn,
    input  logic                miss_req,
    input  mem_pkg::mem_issue_t miss_info,
    input  logic                sb_empty,
    input  logic                sb_full,
    input  mem_pkg::sb_entry_t  sb_head,
    output logic                sb_pop,
    output mem_pkg::maddr_t     mem_addr,
    output logic                mem_we,
    output mem_pkg::word_t      mem_wdata,
    input  mem_pkg::word_t      mem_rdata,
    output logic                timer_start,
    input  logic                timer_done,
    output logic                fill_en,
    output mem_pkg::maddr_t     fill_addr,
    output mem_pkg::complete_t  fill_complete,
    output logic                upd_en,
    output logic                stall
);

    mem_pkg::miss_state_t state;
    mem_pkg::miss_state_t state_next;
    mem_pkg::mem_issue_t  req_q;
    mem_pkg::maddr_t      req_addr;
    logic                 idle;
    logic                 drain;

    assign idle     = (state == mem_pkg::IDLE);
    assign req_addr = req_q.result[mem_pkg::ADDR_LSB +: mem_pkg::MADDR_W];
    assign drain    = idle && !miss_req && !sb_empty;  // A new miss wins the port

    always_comb begin
        state_next = state;
        case (state)
            mem_pkg::IDLE:   if (miss_req) state_next = mem_pkg::REFILL;
            mem_pkg::REFILL: if (timer_done) state_next = mem_pkg::FILL;
            mem_pkg::FILL:   state_next = mem_pkg::IDLE;
            default:         state_next = mem_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) state <= mem_pkg::IDLE;
        else state <= state_next;
    end

    always_ff @(posedge clk) begin
        if (idle && miss_req) req_q <= miss_info;
    end

    // Port carries the store head while idle, the miss address otherwise
    assign mem_addr    = idle ? sb_head.addr : req_addr;
    assign mem_we      = drain;
    assign mem_wdata   = sb_head.data;
    assign sb_pop      = drain;
    assign upd_en      = drain;
    assign timer_start = idle && miss_req;
    assign fill_en     = (state == mem_pkg::FILL);
    assign fill_addr   = req_addr;
    assign stall       = !idle || sb_full;

    always_comb begin
        fill_complete.valid = fill_en;
        fill_complete.pc    = req_q.pc;
        fill_complete.dest  = req_q.dest;
        fill_complete.rob   = req_q.rob;
        fill_complete.data  = mem_rdata;  // Read issued during REFILL
    end

    a_done_in_refill: assert property (@(posedge clk) disable iff (!rstn)
        timer_done |-> state == mem_pkg::REFILL);

endmodule

`default_nettype wire

// ==== design/complete_reg.sv ====
`timescale 1ns/1ns
`default_nettype none

module complete_reg (
    input  logic                clk,
    input  logic                rstn,
    input  mem_pkg::alu_issue_t issue0,
    input  mem_pkg::alu_issue_t issue1,
    input  mem_pkg::mem_issue_t issue2,
    input  logic                accept,
    input  mem_pkg::lookup_t    fwd,
    input  mem_pkg::lookup_t    cache,
    input  mem_pkg::complete_t  fill_complete,
    output logic                miss_req,
    output mem_pkg::complete_t  complete0,
    output mem_pkg::complete_t  complete1,
    output mem_pkg::complete_t  complete2
);

    mem_pkg::complete_t lane2_next;
    logic               lane2_ok;
    logic               is_lw;
    logic               is_sw;
    logic               ld_hit;

    function automatic mem_pkg::complete_t alu_done(mem_pkg::alu_issue_t op, logic acc);
        mem_pkg::complete_t c;
        c.valid = op.valid && acc;
        c.pc    = op.pc;
        c.dest  = op.dest;
        c.rob   = op.rob;
        c.data  = op.result;
        return c;
    endfunction

    assign lane2_ok = accept && issue2.valid;
    assign is_lw    = (issue2.optype == mem_pkg::OP_LW);
    assign is_sw    = (issue2.optype == mem_pkg::OP_SW);
    assign ld_hit   = fwd.hit || cache.hit;
    assign miss_req = lane2_ok && is_lw && !ld_hit;

    // Fill first, then ALU, then a load that hit somewhere
    always_comb begin
        lane2_next = '0;
        if (fill_complete.valid) begin
            lane2_next = fill_complete;
        end else if (lane2_ok && !is_lw && !is_sw) begin
            lane2_next.valid = 1'b1;
            lane2_next.pc    = issue2.pc;
            lane2_next.dest  = issue2.dest;
            lane2_next.rob   = issue2.rob;
            lane2_next.data  = issue2.result;
        end else if (lane2_ok && is_lw && ld_hit) begin
            lane2_next.valid = 1'b1;
            lane2_next.pc    = issue2.pc;
            lane2_next.dest  = issue2.dest;
            lane2_next.rob   = issue2.rob;
            lane2_next.data  = fwd.hit ? fwd.data : cache.data;  // Newer store wins
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            complete0 <= '0;
            complete1 <= '0;
            complete2 <= '0;
        end else begin
            complete0 <= alu_done(issue0, accept);
            complete1 <= alu_done(issue1, accept);
            complete2 <= lane2_next;
        end
    end

    a_fill_no_issue: assert property (@(posedge clk) disable iff (!rstn)
        !(fill_complete.valid && lane2_ok));

endmodule

`default_nettype wire

// ==== design/mem_complete_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_complete_top (
    input  logic                clk,
    input  logic                rstn,
    input  mem_pkg::alu_issue_t issue0,
    input  mem_pkg::alu_issue_t issue1,
    input  mem_pkg::mem_issue_t issue2,
    output mem_pkg::complete_t  complete0,
    output mem_pkg::complete_t  complete1,
    output mem_pkg::complete_t  complete2,
    output logic                stall
);

    logic                accept;
    mem_pkg::maddr_t     issue_addr;
    logic                sb_push;
    mem_pkg::sb_entry_t  sb_push_entry;
    logic                sb_pop;
    mem_pkg::sb_entry_t  sb_head;
    logic                sb_empty;
    logic                sb_full;
    mem_pkg::lookup_t    fwd;
    mem_pkg::lookup_t    cache;
    logic                miss_req;
    mem_pkg::maddr_t     mem_addr;
    logic                mem_we;
    mem_pkg::word_t      mem_wdata;
    mem_pkg::word_t      mem_rdata;
    logic                timer_start;
    logic                timer_done;
    logic                fill_en;
    mem_pkg::maddr_t     fill_addr;
    mem_pkg::complete_t  fill_complete;
    logic                upd_en;

    assign accept     = !stall;
    assign issue_addr = issue2.result[mem_pkg::ADDR_LSB +: mem_pkg::MADDR_W];
    assign sb_push    = accept && issue2.valid && (issue2.optype == mem_pkg::OP_SW);

    assign sb_push_entry.addr = issue_addr;
    assign sb_push_entry.data = issue2.store_data;

    store_buffer u_sb (
        .clk(clk), .rstn(rstn),
        .push(sb_push), .push_entry(sb_push_entry),
        .pop(sb_pop), .head(sb_head), .empty(sb_empty), .full(sb_full),
        .load_addr(issue_addr), .fwd(fwd)
    );

    // Store updates reuse the drain write on the memory port
    dcache u_dcache (
        .clk(clk), .rstn(rstn),
        .lookup_addr(issue_addr), .lookup(cache),
        .fill_en(fill_en), .fill_addr(fill_addr), .fill_data(mem_rdata),
        .upd_en(upd_en), .upd_addr(mem_addr), .upd_data(mem_wdata)
    );

    data_mem u_mem (
        .clk(clk), .addr(mem_addr), .we(mem_we), .wdata(mem_wdata), .rdata(mem_rdata)
    );

    refill_timer u_timer (
        .clk(clk), .rstn(rstn), .start(timer_start), .done(timer_done)
    );

    miss_ctrl u_miss (
        .clk(clk), .rstn(rstn),
        .miss_req(miss_req), .miss_info(issue2),
        .sb_empty(sb_empty), .sb_full(sb_full), .sb_head(sb_head), .sb_pop(sb_pop),
        .mem_addr(mem_addr), .mem_we(mem_we), .mem_wdata(mem_wdata),
        .mem_rdata(mem_rdata),
        .timer_start(timer_start), .timer_done(timer_done),
        .fill_en(fill_en), .fill_addr(fill_addr), .fill_complete(fill_complete),
        .upd_en(upd_en), .stall(stall)
    );

    complete_reg u_creg (
        .clk(clk), .rstn(rstn),
        .issue0(issue0), .issue1(issue1), .issue2(issue2), .accept(accept),
        .fwd(fwd), .cache(cache), .fill_complete(fill_complete),
        .miss_req(miss_req),
        .complete0(complete0), .complete1(complete1), .complete2(complete2)
    );

endmodule

`default_nettype wire

// ==== dv/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

function automatic mem_pkg::maddr_t word_addr(input mem_pkg::word_t a);
    return a[mem_pkg::ADDR_LSB +: mem_pkg::MADDR_W];
endfunction

function automatic mem_pkg::word_t byte_addr(input mem_pkg::maddr_t w);
    return {22'd0, w, 2'b00};
endfunction

task automatic compare_field(input string sig, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        stop_on_error($sformatf("Fail at %0t ns: %s expected %h got %h", $time, sig, exp, got));
    end
endtask

task automatic check_complete(input string name, input mem_pkg::complete_t got,
                              input mem_pkg::complete_t exp);
    compare_field({name, ".valid"}, 32'(got.valid), 32'(exp.valid));
    if (exp.valid) begin
        compare_field({name, ".pc"}, got.pc, exp.pc);
        compare_field({name, ".dest"}, 32'(got.dest), 32'(exp.dest));
        compare_field({name, ".rob"}, 32'(got.rob), 32'(exp.rob));
        compare_field({name, ".data"}, got.data, exp.data);
    end
endtask

task automatic check_stall(input logic got, input logic exp);
    compare_field("stall", 32'(got), 32'(exp));
endtask

task automatic make_alu(input mem_pkg::word_t data, output mem_pkg::alu_issue_t op);
    op        = '0;
    op.valid  = 1'b1;
    op.pc     = pc_ctr;
    op.dest   = rob_ctr ^ 6'h2a;
    op.rob    = rob_ctr;
    op.result = data;
    pc_ctr    = pc_ctr + 32'd4;
    rob_ctr   = rob_ctr + 6'd1;
endtask

task automatic make_mem(input mem_pkg::optype_t t, input mem_pkg::word_t result,
                        input mem_pkg::word_t sdata, output mem_pkg::mem_issue_t op);
    op            = '0;
    op.valid      = 1'b1;
    op.pc         = pc_ctr;
    op.optype     = t;
    op.dest       = rob_ctr ^ 6'h15;
    op.rob        = rob_ctr;
    op.result     = result;  // Address for LW and SW
    op.store_data = sdata;
    pc_ctr        = pc_ctr + 32'd4;
    rob_ctr       = rob_ctr + 6'd1;
endtask

task automatic add_expect(input logic [1:0] lane, input mem_pkg::pc_t pc,
                          input mem_pkg::preg_t dest, input mem_pkg::rob_t rob,
                          input mem_pkg::word_t data);
    expect_t e;
    e.lane    = lane;
    e.c.valid = 1'b1;
    e.c.pc    = pc;
    e.c.dest  = dest;
    e.c.rob   = rob;
    e.c.data  = data;
    exp_q.push_back(e);
endtask

// Stores update the model in program order, so a load sees every older store
task automatic record_expected(input mem_pkg::alu_issue_t a0, input mem_pkg::alu_issue_t a1,
                               input mem_pkg::mem_issue_t m2);
    if (a0.valid) add_expect(2'd0, a0.pc, a0.dest, a0.rob, a0.result);
    if (a1.valid) add_expect(2'd1, a1.pc, a1.dest, a1.rob, a1.result);
    if (m2.valid) begin
        if (m2.optype == mem_pkg::OP_SW) begin
            ref_mem[word_addr(m2.result)] = m2.store_data;  // No completion
        end else if (m2.optype == mem_pkg::OP_LW) begin
            add_expect(2'd2, m2.pc, m2.dest, m2.rob, ref_mem[word_addr(m2.result)]);
        end else begin
            add_expect(2'd2, m2.pc, m2.dest, m2.rob, m2.result);
        end
    end
endtask

task automatic scan_lane(input logic [1:0] lane, input mem_pkg::complete_t got);
    int idx;
    idx = -1;
    if (got.valid) begin
        foreach (exp_q[i]) begin
            if (idx < 0 && exp_q[i].lane == lane && exp_q[i].c.rob == got.rob) idx = i;
        end
        if (idx < 0) begin
            stop_on_error($sformatf("complete%0d shows rob %0d but no such operation is pending",
                                    lane, got.rob));
        end else begin
            check_complete($sformatf("complete%0d", lane), got, exp_q[idx].c);
            exp_q.delete(idx);
        end
    end
endtask

task automatic scan_all();
    scan_lane(2'd0, complete0);
    scan_lane(2'd1, complete1);
    scan_lane(2'd2, complete2);
endtask

task automatic next_cycle();
    @(posedge clk);
    @(negedge clk);
    scan_all();
endtask

task automatic idle_cycles(input int n);
    repeat (n) next_cycle();
endtask

task automatic flush();
    while (exp_q.size() != 0) next_cycle();
endtask

// One-cycle results must already be matched right after the issue edge
task automatic require_all_done(input string what);
    if (exp_q.size() != 0) begin
        stop_on_error($sformatf("%s did not complete on the cycle after issue", what));
    end
endtask

// Called on a falling edge and holds the inputs while stall is high
task automatic issue_ops(input mem_pkg::alu_issue_t a0, input mem_pkg::alu_issue_t a1,
                         input mem_pkg::mem_issue_t m2);
    issue0 = a0;
    issue1 = a1;
    issue2 = m2;
    while (stall) next_cycle();
    record_expected(a0, a1, m2);
    @(posedge clk);
    @(negedge clk);
    issue0 = '0;
    issue1 = '0;
    issue2 = '0;
    scan_all();
endtask

task automatic mem_op(input mem_pkg::optype_t t, input mem_pkg::maddr_t a,
                      input mem_pkg::word_t sdata);
    mem_pkg::mem_issue_t m2;
    make_mem(t, byte_addr(a), sdata, m2);
    issue_ops('0, '0, m2);
endtask

task automatic test_reset();
    mem_pkg::complete_t none;
    none = '0;
    check_complete("complete0", complete0, none);
    check_complete("complete1", complete1, none);
    check_complete("complete2", complete2, none);
    check_stall(stall, 1'b0);
endtask

task automatic test_alu_pass();
    mem_pkg::alu_issue_t a0;
    mem_pkg::alu_issue_t a1;
    mem_pkg::mem_issue_t m2;
    for (int k = 0; k < 4; k++) begin
        make_alu(32'h1000_0000 + 32'(k), a0);
        make_alu(32'hbeef_0000 ^ 32'(k), a1);
        make_mem(4'(k + 1), 32'h0dd0_0000 + 32'(k), '0, m2);  // Non-memory optypes
        issue_ops(a0, a1, m2);
        require_all_done("ALU pass-through");
    end
    flush();
endtask

task automatic test_store_load();
    mem_op(mem_pkg::OP_SW, 8'h21, 32'hcafe_0001);
    mem_op(mem_pkg::OP_LW, 8'h21, '0);  // Forwarded from the buffer
    require_all_done("Forwarded load");
    mem_op(mem_pkg::OP_SW, 8'h21, 32'hcafe_0002);
    mem_op(mem_pkg::OP_LW, 8'h21, '0);
    require_all_done("Forwarded load");
    flush();
    idle_cycles(3);
    mem_op(mem_pkg::OP_LW, 8'h21, '0);  // Refilled from memory
    mem_op(mem_pkg::OP_LW, 8'h21, '0);
    require_all_done("Cache hit load");
    flush();
endtask

task automatic test_load_miss();
    mem_op(mem_pkg::OP_SW, 8'h90, 32'h5a5a_1234);
    idle_cycles(3);
    mem_op(mem_pkg::OP_LW, 8'h90, '0);
    check_stall(stall, 1'b1);
    flush();
    check_stall(stall, 1'b0);  // Falls with the fill completion
    mem_op(mem_pkg::OP_LW, 8'h90, '0);
    check_stall(stall, 1'b0);
    require_all_done("Cache hit load");
    flush();
endtask

task automatic test_back_pressure();
    for (int k = 0; k < 5; k++) mem_op(mem_pkg::OP_SW, 8'h30 + 8'(k), 32'h7700_0000 + 32'(k));
    for (int k = 0; k < 5; k++) mem_op(mem_pkg::OP_LW, 8'h30 + 8'(k), '0);
    flush();
endtask

task automatic test_random_mix();
    logic [31:0]         r;
    logic [31:0]         data;
    logic [31:0]         t;
    mem_pkg::maddr_t     addr;
    mem_pkg::alu_issue_t a0;
    mem_pkg::alu_issue_t a1;
    mem_pkg::mem_issue_t m2;
    for (int k = 0; k < 32; k++) begin
        draw_bits(32, data);
        mem_op(mem_pkg::OP_SW, 8'hc0 + 8'(k), data);
    end
    repeat (RAND_OPS) begin
        a0 = '0;
        a1 = '0;
        draw_bits(1, r);
        if (r[0]) begin
            draw_bits(32, data);
            make_alu(data, a0);
        end
        draw_bits(1, r);
        if (r[0]) begin
            draw_bits(32, data);
            make_alu(data, a1);
        end
        draw_bits(5, r);
        addr = 8'hc0 | {3'b000, r[4:0]};  // 32 words over two tags per cache line
        draw_bits(32, data);
        draw_bits(2, r);
        case (r[1:0])
            2'd0: begin
                draw_bits(4, t);
                if (t[3:0] == mem_pkg::OP_LW || t[3:0] == mem_pkg::OP_SW) t = '0;
                make_mem(t[3:0], data, '0, m2);
            end
            2'd1: make_mem(mem_pkg::OP_SW, byte_addr(addr), data, m2);
            default: make_mem(mem_pkg::OP_LW, byte_addr(addr), '0, m2);
        endcase
        issue_ops(a0, a1, m2);
    end
    flush();
endtask

`endif

// ==== dv/tb_mem_complete.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_mem_complete;

    localparam logic [31:0] LFSR_SEED = 32'h40ec;
    localparam int RAND_OPS    = 300;
    localparam int NUM_OPS     = 24 + 32 + RAND_OPS;  // Directed, warm-up stores, random
    localparam int TIMEOUT_CYC = NUM_OPS * (mem_pkg::REFILL_CYCLES + 4) + 200;

    // One expected completion tagged with the lane it must come out on
    typedef struct packed {
        logic [1:0]         lane;
        mem_pkg::complete_t c;
    } expect_t;

    logic                clk;
    logic                rstn;
    mem_pkg::alu_issue_t issue0;
    mem_pkg::alu_issue_t issue1;
    mem_pkg::mem_issue_t issue2;
    mem_pkg::complete_t  complete0;
    mem_pkg::complete_t  complete1;
    mem_pkg::complete_t  complete2;
    logic                stall;

    mem_pkg::word_t ref_mem [mem_pkg::MEM_WORDS];  // Memory as the program sees it
    expect_t        exp_q [$];
    logic [31:0]    lfsr_state;
    mem_pkg::rob_t  rob_ctr;
    mem_pkg::pc_t   pc_ctr;
    int             cycles = 0;

    mem_complete_top DUT (
        .clk(clk),
        .rstn(rstn),
        .issue0(issue0),
        .issue1(issue1),
        .issue2(issue2),
        .complete0(complete0),
        .complete1(complete1),
        .complete2(complete2),
        .stall(stall)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > TIMEOUT_CYC) begin
            stop_on_error($sformatf("Timeout after %0d cycles, %0d completions never arrived",
                                    cycles, exp_q.size()));
        end
    end

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "Run stopped at the first error");
    endtask

    // Galois form with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    `include "tb_checks.svh"

    initial begin
        rstn       = 1'b0;
        issue0     = '0;
        issue1     = '0;
        issue2     = '0;
        lfsr_state = LFSR_SEED;
        rob_ctr    = '0;
        pc_ctr     = 32'h0000_1000;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        test_reset();
        test_alu_pass();
        test_store_load();
        test_load_miss();
        test_back_pressure();
        test_random_mix();
        idle_cycles(4);

        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
design/mem_pkg.sv
design/store_buffer.sv
design/dcache.sv
design/data_mem.sv
design/refill_timer.sv
design/miss_ctrl.sv
design/complete_reg.sv
design/mem_complete_top.sv
+incdir+dv
dv/tb_mem_complete.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run tb_mem_complete and check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	rm -f $(LOG)
	verilator --binary --timing --assert -Wno-fatal -f build.f \
		--top-module tb_mem_complete -Mdir obj_dir -o sim_tb
	-./obj_dir/sim_tb > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qF ">>> PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
